/* source/cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// cache geometry, direct mapped
`define CACHE_BLOCKS      8
`define CACHE_WORDS       4
`define CACHE_WORD_BITS   32

// processor word address
`define CACHE_ADDR_BITS   30
`define CACHE_INDEX_BITS  3
`define CACHE_OFFSET_BITS 2

// address bits above index and offset
`define CACHE_TAG_BITS    (`CACHE_ADDR_BITS - `CACHE_INDEX_BITS - `CACHE_OFFSET_BITS)

// one block as seen by memory
`define CACHE_LINE_BITS   (`CACHE_WORDS * `CACHE_WORD_BITS)

// memory is addressed by line
`define CACHE_MEM_ADDR_BITS (`CACHE_ADDR_BITS - `CACHE_OFFSET_BITS)

`endif

/* source/cache_pkg.sv */
package cache_pkg;

    `include "cache_config.svh"

    typedef logic [`CACHE_WORD_BITS-1:0]   word_t;
    typedef logic [`CACHE_LINE_BITS-1:0]   line_t;
    typedef logic [`CACHE_TAG_BITS-1:0]    tag_t;
    typedef logic [`CACHE_INDEX_BITS-1:0]  index_t;
    typedef logic [`CACHE_OFFSET_BITS-1:0] offset_t;

    // overlays the 30-bit processor word address
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } proc_addr_t;

    // everything driven toward memory
    typedef struct packed {
        logic                            read;
        logic                            write;
        logic [`CACHE_MEM_ADDR_BITS-1:0] addr;
        line_t                           wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        LOOKUP,
        WRITEBACK,
        REFILL
    } cache_state_e;

endpackage

/* source/cache_tag_store.sv */
`timescale 1ns/1ps

`include "cache_config.svh"

module cache_tag_store
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       proc_reset,
    input  proc_addr_t addr,
    input  logic       word_write_en,
    input  logic       refill_en,
    output logic       hit,
    output logic       victim_dirty,
    output tag_t       victim_tag
);

    logic [`CACHE_BLOCKS-1:0] valid_bits;
    logic [`CACHE_BLOCKS-1:0] dirty_bits;
    tag_t                     tag_mem [`CACHE_BLOCKS];

    // indexed entry
    logic entry_valid;
    tag_t entry_tag;

    assign entry_valid = valid_bits[addr.index];
    assign entry_tag   = tag_mem[addr.index];

    assign hit          = entry_valid && (entry_tag == addr.tag);
    assign victim_dirty = dirty_bits[addr.index];
    assign victim_tag   = entry_tag;

    // valid and dirty flags
    always_ff @(posedge clk) begin
        if (proc_reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (refill_en) begin
            valid_bits[addr.index] <= 1'b1;
            dirty_bits[addr.index] <= 1'b0;
        end else if (word_write_en) begin
            dirty_bits[addr.index] <= 1'b1;
        end
    end

    // tag only changes when a new block arrives
    always_ff @(posedge clk) begin
        if (refill_en) begin
            tag_mem[addr.index] <= addr.tag;
        end
    end

endmodule

/* source/cache_data_store.sv */
`timescale 1ns/1ps

`include "cache_config.svh"

module cache_data_store
    import cache_pkg::*;
(
    input  logic       clk,
    input  proc_addr_t addr,
    input  word_t      wdata,
    input  logic       word_write_en,
    input  logic       refill_en,
    input  line_t      refill_line,
    output word_t      rdata,
    output line_t      victim_line
);

    line_t data_mem [`CACHE_BLOCKS];

    line_t indexed_line;

    assign indexed_line = data_mem[addr.index];

    // word select within the indexed block
    assign rdata = indexed_line[addr.offset * `CACHE_WORD_BITS +: `CACHE_WORD_BITS];

    // whole block goes out on a write-back
    assign victim_line = indexed_line;

    always_ff @(posedge clk) begin
        if (refill_en) begin
            data_mem[addr.index] <= refill_line;
        end else if (word_write_en) begin
            data_mem[addr.index][addr.offset * `CACHE_WORD_BITS +: `CACHE_WORD_BITS] <= wdata;
        end
    end

endmodule

/* source/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       proc_reset,
    input  logic       read,
    input  logic       write,
    input  proc_addr_t addr,
    input  logic       hit,
    input  logic       victim_dirty,
    input  tag_t       victim_tag,
    input  line_t      victim_line,
    input  logic       mem_ready,
    output logic       stall,
    output logic       word_write_en,
    output logic       refill_en,
    output mem_req_t   mem_req
);

    cache_state_e state_q;
    cache_state_e state_d;

    logic request;
    logic miss;

    assign request = read || write;
    assign miss    = request && !hit;

    always_comb begin
        state_d = state_q;
        case (state_q)
            LOOKUP: begin
                if (miss) begin
                    state_d = victim_dirty ? WRITEBACK : REFILL;
                end
            end
            WRITEBACK: begin
                if (mem_ready) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (mem_ready) begin
                    state_d = LOOKUP;
                end
            end
            default: state_d = LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state_q <= LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

    // stall rises in the miss cycle itself
    assign stall = (state_q != LOOKUP) || miss;

    assign word_write_en = (state_q == LOOKUP) && write && hit;
    assign refill_en     = (state_q == REFILL) && mem_ready;

    always_comb begin
        mem_req.read  = (state_q == REFILL);
        mem_req.write = (state_q == WRITEBACK);
        // victim line address while writing back
        if (state_q == WRITEBACK) begin
            mem_req.addr = {victim_tag, addr.index};
        end else begin
            mem_req.addr = {addr.tag, addr.index};
        end
        mem_req.wdata = victim_line;
    end

endmodule

/* source/cache_top.sv */
`timescale 1ns/1ps

`include "cache_config.svh"

module cache_top
    import cache_pkg::*;
(
    input  logic                            clk,
    input  logic                            proc_reset,
    input  logic                            proc_read,
    input  logic                            proc_write,
    input  logic [`CACHE_ADDR_BITS-1:0]     proc_addr,
    input  word_t                           proc_wdata,
    output word_t                           proc_rdata,
    output logic                            proc_stall,
    output logic                            mem_read,
    output logic                            mem_write,
    output logic [`CACHE_MEM_ADDR_BITS-1:0] mem_addr,
    output line_t                           mem_wdata,
    input  line_t                           mem_rdata,
    input  logic                            mem_ready
);

    proc_addr_t addr;
    mem_req_t   mem_req;

    logic  hit;
    logic  victim_dirty;
    tag_t  victim_tag;
    line_t victim_line;
    logic  word_write_en;
    logic  refill_en;

    assign addr = proc_addr_t'(proc_addr);

    cache_tag_store u_tag_store (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .addr         (addr),
        .word_write_en(word_write_en),
        .refill_en    (refill_en),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    // refill line taken straight from memory
    cache_data_store u_data_store (
        .clk          (clk),
        .addr         (addr),
        .wdata        (proc_wdata),
        .word_write_en(word_write_en),
        .refill_en    (refill_en),
        .refill_line  (mem_rdata),
        .rdata        (proc_rdata),
        .victim_line  (victim_line)
    );

    cache_ctrl u_ctrl (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .read         (proc_read),
        .write        (proc_write),
        .addr         (addr),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .mem_ready    (mem_ready),
        .stall        (proc_stall),
        .word_write_en(word_write_en),
        .refill_en    (refill_en),
        .mem_req      (mem_req)
    );

    assign mem_read  = mem_req.read;
    assign mem_write = mem_req.write;
    assign mem_addr  = mem_req.addr;
    assign mem_wdata = mem_req.wdata;

endmodule

/* test/cache_chk.sv */
`timescale 1ns/1ps

`include "cache_config.svh"

module cache_chk
    import cache_pkg::*;
(
    input logic                            clk,
    input logic                            proc_reset,
    input logic                            mem_read,
    input logic                            mem_write,
    input logic [`CACHE_MEM_ADDR_BITS-1:0] mem_addr,
    input line_t                           mem_wdata,
    input logic                            mem_ready
);

    // one memory phase at a time
    a_read_write_excl: assert property (
        @(posedge clk) disable iff (proc_reset)
        !(mem_read && mem_write)
    ) else $error("mem_read and mem_write both high");

    // request held until memory answers
    a_req_stable: assert property (
        @(posedge clk) disable iff (proc_reset)
        (mem_read || mem_write) && !mem_ready
            |=> $stable({mem_read, mem_write, mem_addr, mem_wdata})
    ) else $error("memory request changed before mem_ready");

    a_idle_after_reset: assert property (
        @(posedge clk)
        proc_reset |=> !mem_read && !mem_write
    ) else $error("memory request active right after reset");

endmodule

/* test/cache_tb.sv */
`timescale 1ns/1ps

`include "cache_config.svh"

module cache_tb
    import cache_pkg::*;
();

    localparam int STIM_MAX     = 64;
    localparam int STIM_COLS    = 6;
    localparam int MEM_LINES    = 64;
    localparam int MEM_WORDS    = MEM_LINES * `CACHE_WORDS;
    localparam int RESET_CYCLES = 8;
    localparam int TEST_CYCLES  = 20;

    localparam logic [31:0] OP_WRITE = 32'h1;
    localparam logic [31:0] OP_RESET = 32'h2;
    localparam logic [31:0] OP_END   = 32'hf;

    logic                            clk = 1'b0;
    logic                            proc_reset;
    logic                            proc_read;
    logic                            proc_write;
    logic [`CACHE_ADDR_BITS-1:0]     proc_addr;
    word_t                           proc_wdata;
    word_t                           proc_rdata;
    logic                            proc_stall;
    logic                            mem_read;
    logic                            mem_write;
    logic [`CACHE_MEM_ADDR_BITS-1:0] mem_addr;
    line_t                           mem_wdata;
    line_t                           mem_rdata;
    logic                            mem_ready;

    logic [31:0] stim [STIM_MAX*STIM_COLS];
    line_t       mem_lines [MEM_LINES];
    // word-level view of what memory should hold
    word_t       ref_words [MEM_WORDS];

    int rd_phases = 0;
    int wr_phases = 0;
    int wb_errors = 0;

    always #5 clk = ~clk;

    cache_top u_cache_top (
        .clk       (clk),
        .proc_reset(proc_reset),
        .proc_read (proc_read),
        .proc_write(proc_write),
        .proc_addr (proc_addr),
        .proc_wdata(proc_wdata),
        .proc_rdata(proc_rdata),
        .proc_stall(proc_stall),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    bind cache_top cache_chk u_chk (
        .clk       (clk),
        .proc_reset(proc_reset),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready)
    );

    // A5 in the top byte, word address below
    function automatic word_t rule_word(input logic [7:0] word_addr);
        return {8'hA5, 16'h0000, word_addr};
    endfunction

    function automatic line_t expected_line(input logic [5:0] line_addr);
        line_t line;
        for (int w = 0; w < `CACHE_WORDS; w++) begin
            line[w*`CACHE_WORD_BITS +: `CACHE_WORD_BITS] = ref_words[{line_addr, w[1:0]}];
        end
        return line;
    endfunction

    task automatic run_access(input logic is_write, input logic [`CACHE_ADDR_BITS-1:0] addr,
                              input word_t wdata, output word_t rdata,
                              output logic stalled);
        @(posedge clk);
        #1;
        proc_read  = !is_write;
        proc_write = is_write;
        proc_addr  = addr;
        proc_wdata = wdata;
        // access completes on the first edge with stall low
        @(negedge clk);
        stalled = proc_stall;
        while (proc_stall) begin
            @(negedge clk);
        end
        rdata = proc_rdata;
        @(posedge clk);
        #1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1 proc_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 proc_reset = 1'b0;
        // dirty blocks are lost, memory holds the valid data now
        for (int a = 0; a < MEM_WORDS; a++) begin
            ref_words[a] = mem_lines[a >> 2][(a & 3) * `CACHE_WORD_BITS +: `CACHE_WORD_BITS];
        end
    endtask

    task automatic watchdog(input int cycles);
        repeat (cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, a memory phase or stall never ended",
                 cycles);
        $display("Test FAILED");
        $finish;
    endtask

    // memory model, random answer delay per phase
    initial begin
        int   wait_left;
        logic pending;
        void'($urandom(30));
        wait_left = 0;
        pending   = 1'b0;
        mem_ready = 1'b0;
        mem_rdata = '0;
        for (int l = 0; l < MEM_LINES; l++) begin
            for (int w = 0; w < `CACHE_WORDS; w++) begin
                mem_lines[l][w*`CACHE_WORD_BITS +: `CACHE_WORD_BITS] = rule_word({l[5:0], w[1:0]});
            end
        end
        forever begin
            @(posedge clk);
            if (proc_reset) begin
                pending = 1'b0;
                #1 mem_ready = 1'b0;
            end else if (mem_ready) begin
                if (mem_write) begin
                    wr_phases++;
                    if (mem_wdata !== expected_line(mem_addr[5:0])) begin
                        $display("** Error at %0t: mem_wdata = %h, expected %h",
                                 $time, mem_wdata, expected_line(mem_addr[5:0]));
                        wb_errors++;
                    end
                    mem_lines[mem_addr[5:0]] = mem_wdata;
                end
                if (mem_read) begin
                    rd_phases++;
                end
                pending = 1'b0;
                #1 mem_ready = 1'b0;
            end else if (mem_read || mem_write) begin
                if (!pending) begin
                    pending   = 1'b1;
                    wait_left = int'($urandom % 6);
                end
                if (wait_left == 0) begin
                    #1;
                    mem_rdata = mem_lines[mem_addr[5:0]];
                    mem_ready = 1'b1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin
        int                          n_tests;
        int                          fail_count;
        int                          rd_before;
        int                          wr_before;
        int                          wb_before;
        int                          exp_rd;
        int                          exp_wr;
        logic [31:0]                 op;
        logic [`CACHE_ADDR_BITS-1:0] addr;
        word_t                       wdata;
        word_t                       exp_rdata;
        word_t                       rdata;
        logic                        stalled;
        logic                        ok;
        string                       op_name;

        proc_reset = 1'b1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            ref_words[a] = rule_word(a[7:0]);
        end
        $readmemh("test/cache_stim.txt", stim);
        n_tests = 0;
        while (n_tests < STIM_MAX && stim[n_tests*STIM_COLS] != OP_END) begin
            n_tests++;
        end
        fork
            watchdog((n_tests + 1) * TEST_CYCLES);
        join_none

        repeat (RESET_CYCLES) @(posedge clk);
        #1 proc_reset = 1'b0;

        fail_count = 0;
        for (int t = 0; t < n_tests; t++) begin
            op        = stim[t*STIM_COLS];
            addr      = stim[t*STIM_COLS+1][`CACHE_ADDR_BITS-1:0];
            wdata     = stim[t*STIM_COLS+2];
            exp_rdata = stim[t*STIM_COLS+3];
            exp_rd    = int'(stim[t*STIM_COLS+4]);
            exp_wr    = int'(stim[t*STIM_COLS+5]);
            rd_before = rd_phases;
            wr_before = wr_phases;
            wb_before = wb_errors;
            ok        = 1'b1;
            rdata     = '0;
            stalled   = 1'b0;
            case (op)
                OP_RESET: begin
                    op_name = "reset";
                    apply_reset();
                end
                OP_WRITE: begin
                    op_name = "write";
                    run_access(1'b1, addr, wdata, rdata, stalled);
                    ref_words[addr[7:0]] = wdata;
                end
                default: begin
                    op_name = "read";
                    run_access(1'b0, addr, wdata, rdata, stalled);
                    if (rdata !== exp_rdata) begin
                        $display("** Error at %0t: proc_rdata = %h, expected %h",
                                 $time, rdata, exp_rdata);
                        ok = 1'b0;
                    end
                end
            endcase
            // only a miss stalls in the request cycle
            if (stalled !== (exp_rd != 0)) begin
                $display("** Error at %0t: proc_stall = %b, expected %b",
                         $time, stalled, exp_rd != 0);
                ok = 1'b0;
            end
            if (rd_phases - rd_before != exp_rd) begin
                $display("** Error at %0t: mem_read phases = %0d, expected %0d",
                         $time, rd_phases - rd_before, exp_rd);
                ok = 1'b0;
            end
            if (wr_phases - wr_before != exp_wr) begin
                $display("** Error at %0t: mem_write phases = %0d, expected %0d",
                         $time, wr_phases - wr_before, exp_wr);
                ok = 1'b0;
            end
            if (wb_errors != wb_before) begin
                ok = 1'b0;
            end
            if (!ok) begin
                fail_count++;
            end
            $display("test %0d %s %h: %s", t, op_name, addr, ok ? "passed" : "failed");
        end

        $display("%0d tests run, %0d passed, %0d failed",
                 n_tests, n_tests - fail_count, fail_count);
        if (fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* test/cache_stim.txt */
// columns: op, word address, write data, expected read data, mem_read phases, mem_write phases
// op 0 read, 1 write, 2 reset, f end of list
0 00000004 00000000 a5000004 1 0
0 00000005 00000000 a5000005 0 0
1 00000006 11111111 00000000 0 0
0 00000006 00000000 11111111 0 0
0 00000007 00000000 a5000007 0 0
// write miss, allocate then merge
1 0000002a 22222222 00000000 1 0
0 0000002a 00000000 22222222 0 0
0 00000029 00000000 a5000029 0 0
// dirty eviction at index 1
0 00000024 00000000 a5000024 1 1
0 00000006 00000000 11111111 1 0
// clean eviction at index 1
0 00000044 00000000 a5000044 1 0
0 00000045 00000000 a5000045 0 0
0 00000010 00000000 a5000010 1 0
0 00000013 00000000 a5000013 0 0
// reset in mid-run
2 00000000 00000000 00000000 0 0
0 00000013 00000000 a5000013 1 0
0 00000010 00000000 a5000010 0 0
1 0000002a 33333333 00000000 1 0
0 00000029 00000000 a5000029 0 0
0 0000002a 00000000 33333333 0 0
1 0000002b 44444444 00000000 0 0
0 0000004a 00000000 a500004a 1 1
0 0000002b 00000000 44444444 1 0
0 0000002a 00000000 33333333 0 0
1 000000e0 55555555 00000000 1 0
0 000000c0 00000000 a50000c0 1 1
0 000000e0 00000000 55555555 1 0
f 00000000 00000000 00000000 0 0

/* sources.f */
+incdir+source
source/cache_pkg.sv
source/cache_tag_store.sv
source/cache_data_store.sv
source/cache_ctrl.sv
source/cache_top.sv
test/cache_chk.sv
test/cache_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= cache_tb
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --timing --assert --timescale 1ns/1ps
PASS_TEXT  ?= Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
